// File: Makefile
TOP = tb_soc_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// File: axi_addr_decoder.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module axi_addr_decoder (
	input  logic    clk_i,
	input  logic    rst_i,
	axi_lite_if.slv up,   // From bridge
	axi_lite_if.mst ram,
	axi_lite_if.mst uart
);

soc_pkg::slave_sel_e dec_sel, sel_q, sel;
logic               busy_q;        // One transaction in flight
logic               err_rvalid_q;  // Decode error responder
logic               err_bvalid_q;
logic [`DATA_W-1:0] req_addr;
logic               ar_hs, aw_hs, r_hs, b_hs;

function automatic soc_pkg::slave_sel_e decode(input logic [`DATA_W-1:0] addr);
	logic [`DATA_W-`SEL_LSB-1:0] field;
	field = addr[`DATA_W-1:`SEL_LSB];
	if (field == (`DATA_W-`SEL_LSB)'(`SEL_RAM))
		return soc_pkg::SEL_RAM_T;
	if (field == (`DATA_W-`SEL_LSB)'(`SEL_UART))
		return soc_pkg::SEL_UART_T;
	return soc_pkg::SEL_NONE_T;
endfunction

assign req_addr = up.arvalid ? up.araddr : up.awaddr;
assign dec_sel  = decode(req_addr);
assign sel      = busy_q ? sel_q : dec_sel; // Live decode only before address transfer

// Valids and response readies go to the selected slave only
assign ram.arvalid  = up.arvalid && (sel == soc_pkg::SEL_RAM_T);
assign ram.awvalid  = up.awvalid && (sel == soc_pkg::SEL_RAM_T);
assign ram.wvalid   = up.wvalid  && (sel == soc_pkg::SEL_RAM_T);
assign ram.rready   = up.rready  && (sel == soc_pkg::SEL_RAM_T);
assign ram.bready   = up.bready  && (sel == soc_pkg::SEL_RAM_T);
assign uart.arvalid = up.arvalid && (sel == soc_pkg::SEL_UART_T);
assign uart.awvalid = up.awvalid && (sel == soc_pkg::SEL_UART_T);
assign uart.wvalid  = up.wvalid  && (sel == soc_pkg::SEL_UART_T);
assign uart.rready  = up.rready  && (sel == soc_pkg::SEL_UART_T);
assign uart.bready  = up.bready  && (sel == soc_pkg::SEL_UART_T);

// Payload shared, qualified by the valids above
assign ram.araddr  = up.araddr;
assign ram.awaddr  = up.awaddr;
assign ram.wdata   = up.wdata;
assign ram.wstrb   = up.wstrb;
assign uart.araddr = up.araddr;
assign uart.awaddr = up.awaddr;
assign uart.wdata  = up.wdata;
assign uart.wstrb  = up.wstrb;

always_comb begin
	case (sel)
		soc_pkg::SEL_RAM_T: begin
			up.arready = ram.arready;
			up.awready = ram.awready;
			up.wready  = ram.wready;
			up.rvalid  = ram.rvalid;
			up.rdata   = ram.rdata;
			up.rresp   = ram.rresp;
			up.bvalid  = ram.bvalid;
			up.bresp   = ram.bresp;
		end
		soc_pkg::SEL_UART_T: begin
			up.arready = uart.arready;
			up.awready = uart.awready;
			up.wready  = uart.wready;
			up.rvalid  = uart.rvalid;
			up.rdata   = uart.rdata;
			up.rresp   = uart.rresp;
			up.bvalid  = uart.bvalid;
			up.bresp   = uart.bresp;
		end
		default: begin
			// Unmapped, AW and W taken together
			up.arready = !busy_q;
			up.awready = !busy_q && up.wvalid;
			up.wready  = !busy_q && up.awvalid;
			up.rvalid  = err_rvalid_q;
			up.rdata   = '0;
			up.rresp   = soc_pkg::DECERR;
			up.bvalid  = err_bvalid_q;
			up.bresp   = soc_pkg::DECERR;
		end
	endcase
end

assign ar_hs = up.arvalid && up.arready;
assign aw_hs = up.awvalid && up.awready; // W transfers in the same cycle
assign r_hs  = up.rvalid && up.rready;
assign b_hs  = up.bvalid && up.bready;

always_ff @(posedge clk_i) begin
	if (rst_i) begin
		busy_q       <= 1'b0;
		sel_q        <= soc_pkg::SEL_NONE_T;
		err_rvalid_q <= 1'b0;
		err_bvalid_q <= 1'b0;
	end else begin
		if (ar_hs || aw_hs) begin
			busy_q <= 1'b1;
			sel_q  <= dec_sel; // Hold target until response
		end else if (r_hs || b_hs) begin
			busy_q <= 1'b0;
		end
		if (ar_hs && dec_sel == soc_pkg::SEL_NONE_T)
			err_rvalid_q <= 1'b1;
		else if (r_hs)
			err_rvalid_q <= 1'b0;
		if (aw_hs && dec_sel == soc_pkg::SEL_NONE_T)
			err_bvalid_q <= 1'b1;
		else if (b_hs)
			err_bvalid_q <= 1'b0;
	end
end

// Never two slaves addressed at once
assert property (@(posedge clk_i) disable iff (rst_i)
	$onehot0({ram.arvalid || ram.awvalid || ram.wvalid,
	          uart.arvalid || uart.awvalid || uart.wvalid}))
	else $error("axi_addr_decoder: more than one slave selected");

endmodule

// File: axi_lite_if.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

interface axi_lite_if;
	// Read address (AR)
	logic               arvalid;
	logic               arready;
	logic [`DATA_W-1:0] araddr;
	// Read data (R)
	logic               rvalid;
	logic               rready;
	logic [`DATA_W-1:0] rdata;
	soc_pkg::axi_resp_e rresp;
	// Write address (AW)
	logic               awvalid;
	logic               awready;
	logic [`DATA_W-1:0] awaddr;
	// Write data (W)
	logic               wvalid;
	logic               wready;
	logic [`DATA_W-1:0] wdata;
	logic [`STRB_W-1:0] wstrb;
	// Write response (B)
	logic               bvalid;
	logic               bready;
	soc_pkg::axi_resp_e bresp;

	modport mst (
		output arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
		input  arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
	);

	modport slv (
		input  arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
		output arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
	);
endinterface

// File: axi_master.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module axi_master (
	input  logic               clk_i,
	input  logic               rst_i,
	// Host handshake
	input  logic               hs_read_i,
	input  logic               hs_write_i,
	input  logic [`DATA_W-1:0] hs_addr_i,
	input  logic [`DATA_W-1:0] hs_data_i,
	input  logic [`STRB_W-1:0] hs_byte_sel_i,
	output logic               hs_ready_o,
	output logic [`DATA_W-1:0] hs_data_o,
	output soc_pkg::axi_resp_e hs_resp_o,
	// AXI-Lite side
	axi_lite_if.mst            bus
);

soc_pkg::mst_state_e state_q;

// Response channels always ready while waiting
assign bus.rready = (state_q == soc_pkg::MST_READ);
assign bus.bready = (state_q == soc_pkg::MST_WRITE);

always_ff @(posedge clk_i) begin
	if (rst_i) begin
		state_q     <= soc_pkg::MST_IDLE;
		bus.arvalid <= 1'b0;
		bus.awvalid <= 1'b0;
		bus.wvalid  <= 1'b0;
		hs_ready_o  <= 1'b0;
	end else begin
		hs_ready_o <= 1'b0; // Single-cycle pulse
		case (state_q)
			soc_pkg::MST_IDLE: begin
				if (hs_read_i) begin
					bus.arvalid <= 1'b1;
					state_q     <= soc_pkg::MST_READ;
				end else if (hs_write_i) begin
					bus.awvalid <= 1'b1; // AW and W raised together
					bus.wvalid  <= 1'b1;
					state_q     <= soc_pkg::MST_WRITE;
				end
			end
			soc_pkg::MST_READ: begin
				if (bus.arready)
					bus.arvalid <= 1'b0; // AR taken
				if (bus.rvalid) begin
					hs_ready_o <= 1'b1;
					state_q    <= soc_pkg::MST_IDLE;
				end
			end
			soc_pkg::MST_WRITE: begin
				if (bus.awready)
					bus.awvalid <= 1'b0;
				if (bus.wready)
					bus.wvalid <= 1'b0;
				if (bus.bvalid) begin
					hs_ready_o <= 1'b1;
					state_q    <= soc_pkg::MST_IDLE;
				end
			end
			default: state_q <= soc_pkg::MST_IDLE;
		endcase
	end
end

// Request payload follows the host while idle and freezes once a strobe is taken
always_ff @(posedge clk_i) begin
	if (state_q == soc_pkg::MST_IDLE) begin
		bus.araddr <= hs_addr_i;
		bus.awaddr <= hs_addr_i;
		bus.wdata  <= hs_data_i;
		bus.wstrb  <= hs_byte_sel_i;
	end
	if (bus.rvalid && bus.rready) begin
		hs_data_o <= bus.rdata;
		hs_resp_o <= bus.rresp;
	end
	if (bus.bvalid && bus.bready)
		hs_resp_o <= bus.bresp; // Read data left as is
end

// Host drives one strobe at a time
assert property (@(posedge clk_i) disable iff (rst_i) !(hs_read_i && hs_write_i))
	else $error("axi_master: read and write strobe together");

endmodule

// File: axi_ram.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module axi_ram (
	input  logic    clk_i,
	input  logic    rst_i,
	axi_lite_if.slv bus
);

logic [`DATA_W-1:0] mem [`RAM_WORDS];
logic               idle;
logic [`RAM_AW-1:0] rd_idx, wr_idx; // Select bits ignored, upper words alias

assign idle   = !bus.rvalid && !bus.bvalid;
assign rd_idx = bus.araddr[`RAM_AW+1:2];
assign wr_idx = bus.awaddr[`RAM_AW+1:2];

assign bus.arready = idle;
assign bus.awready = idle && bus.wvalid; // AW and W only together
assign bus.wready  = idle && bus.awvalid;
assign bus.rresp   = soc_pkg::OKAY;
assign bus.bresp   = soc_pkg::OKAY;

always_ff @(posedge clk_i) begin
	if (rst_i) begin
		bus.rvalid <= 1'b0;
		bus.bvalid <= 1'b0;
	end else begin
		if (bus.arvalid && bus.arready)
			bus.rvalid <= 1'b1; // One cycle after AR
		else if (bus.rready)
			bus.rvalid <= 1'b0;
		if (bus.awvalid && bus.awready)
			bus.bvalid <= 1'b1;
		else if (bus.bready)
			bus.bvalid <= 1'b0;
	end
end

// Array and read data
always_ff @(posedge clk_i) begin
	if (bus.arvalid && bus.arready)
		bus.rdata <= mem[rd_idx];
	if (bus.awvalid && bus.awready) begin
		for (int b = 0; b < `STRB_W; b++) begin
			if (bus.wstrb[b])
				mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8]; // Enabled lanes only
		end
	end
end

endmodule

// File: axi_uart_tx.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module axi_uart_tx (
	input  logic    clk_i,
	input  logic    rst_i,
	axi_lite_if.slv bus,
	output logic    tx_o
);

soc_pkg::uart_state_e                  state_q;
logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_cnt_q;
logic [2:0]                            bit_idx_q;
logic [7:0]                            shift_q;   // LSB goes out first
logic                                  tx_q;
logic                                  busy, bit_end, idle_bus;
logic                                  rd_hs, wr_hs, start;

assign busy     = (state_q != soc_pkg::TX_IDLE);
assign bit_end  = (32'(baud_cnt_q) == `UART_CLKS_PER_BIT - 1);
assign idle_bus = !bus.rvalid && !bus.bvalid;

// Writes stall while a frame is on the line
assign bus.arready = idle_bus;
assign bus.awready = idle_bus && !busy && bus.wvalid;
assign bus.wready  = idle_bus && !busy && bus.awvalid;
assign bus.rresp   = soc_pkg::OKAY;

assign rd_hs = bus.arvalid && bus.arready;
assign wr_hs = bus.awvalid && bus.awready;
assign start = wr_hs && !bus.awaddr[2] && bus.wstrb[0]; // TX register, low byte
assign tx_o  = tx_q;

always_ff @(posedge clk_i) begin
	if (rst_i) begin
		state_q    <= soc_pkg::TX_IDLE;
		baud_cnt_q <= '0;
		bit_idx_q  <= '0;
		tx_q       <= 1'b1; // Line idles high
		bus.rvalid <= 1'b0;
		bus.bvalid <= 1'b0;
	end else begin
		if (rd_hs)
			bus.rvalid <= 1'b1;
		else if (bus.rready)
			bus.rvalid <= 1'b0;
		if (wr_hs)
			bus.bvalid <= 1'b1;
		else if (bus.bready)
			bus.bvalid <= 1'b0;
		if (busy)
			baud_cnt_q <= bit_end ? '0 : baud_cnt_q + 1'b1;
		case (state_q)
			soc_pkg::TX_IDLE: begin
				if (start) begin
					tx_q    <= 1'b0; // Start bit
					state_q <= soc_pkg::TX_START;
				end
			end
			soc_pkg::TX_START: begin
				if (bit_end) begin
					tx_q      <= shift_q[0];
					bit_idx_q <= '0;
					state_q   <= soc_pkg::TX_DATA;
				end
			end
			soc_pkg::TX_DATA: begin
				if (bit_end) begin
					if (bit_idx_q == 3'd7) begin
						tx_q    <= 1'b1; // Stop bit
						state_q <= soc_pkg::TX_STOP;
					end else begin
						tx_q      <= shift_q[1]; // Next bit after shift
						bit_idx_q <= bit_idx_q + 1'b1;
					end
				end
			end
			soc_pkg::TX_STOP: begin
				if (bit_end)
					state_q <= soc_pkg::TX_IDLE;
			end
			default: state_q <= soc_pkg::TX_IDLE;
		endcase
	end
end

always_ff @(posedge clk_i) begin
	if (start)
		shift_q <= bus.wdata[7:0];
	else if (state_q == soc_pkg::TX_DATA && bit_end)
		shift_q <= shift_q >> 1;
	if (rd_hs)
		bus.rdata <= bus.araddr[2] ? {{(`DATA_W-1){1'b0}}, busy} : '0; // Status or zero
	if (wr_hs)
		bus.bresp <= bus.awaddr[2] ? soc_pkg::SLVERR : soc_pkg::OKAY; // Status is read-only
end

// Registered line level agrees with FSM
assert property (@(posedge clk_i) disable iff (rst_i) state_q == soc_pkg::TX_IDLE |-> tx_o)
	else $error("axi_uart_tx: line low while idle");

endmodule

// File: soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus widths
`define DATA_W 32
// One strobe per byte lane
`define STRB_W 4

// Slave select field is addr[31:17]
`define SEL_LSB 17
`define SEL_RAM 0
`define SEL_UART 2

// On-chip RAM, 1 KiB
`define RAM_WORDS 256
// Word index width, log2 of RAM_WORDS
`define RAM_AW 8

// Serial bit period in clocks
`define UART_CLKS_PER_BIT 16

`endif

// File: soc_pkg.sv
package soc_pkg;

	// AXI response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// Decoded target of the address
	typedef enum logic [1:0] {
		SEL_NONE_T, // Unmapped, answered by decoder
		SEL_RAM_T,
		SEL_UART_T
	} slave_sel_e;

	// Bridge FSM
	typedef enum logic [1:0] {
		MST_IDLE,
		MST_READ,
		MST_WRITE
	} mst_state_e;

	// Transmitter FSM, one state per frame part
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} uart_state_e;

endpackage

// File: soc_top.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_top (
	input  logic               clk_i,
	input  logic               rst_i,
	// Host handshake
	input  logic               hs_read_i,
	input  logic               hs_write_i,
	input  logic [`DATA_W-1:0] hs_addr_i,
	input  logic [`DATA_W-1:0] hs_data_i,
	input  logic [`STRB_W-1:0] hs_byte_sel_i,
	output logic               hs_ready_o,
	output logic [`DATA_W-1:0] hs_data_o,
	output logic [1:0]         hs_resp_o,
	// Serial out
	output logic               tx_o
);

axi_lite_if bus_m ();    // Bridge to decoder
axi_lite_if bus_ram ();
axi_lite_if bus_uart ();

axi_master inst_axi_master (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.hs_read_i(hs_read_i),
	.hs_write_i(hs_write_i),
	.hs_addr_i(hs_addr_i),
	.hs_data_i(hs_data_i),
	.hs_byte_sel_i(hs_byte_sel_i),
	.hs_ready_o(hs_ready_o),
	.hs_data_o(hs_data_o),
	.hs_resp_o(hs_resp_o),
	.bus(bus_m.mst)
);

axi_addr_decoder inst_axi_addr_decoder (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.up(bus_m.slv),
	.ram(bus_ram.mst),
	.uart(bus_uart.mst)
);

axi_ram inst_axi_ram (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.bus(bus_ram.slv)
);

axi_uart_tx inst_axi_uart_tx (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.bus(bus_uart.slv),
	.tx_o(tx_o)
);

endmodule

// File: tb_soc_top.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_soc_top;

localparam int CLKS     = `UART_CLKS_PER_BIT;
localparam int N_WORDS  = 32;
localparam int N_XFERS  = 2 * N_WORDS + 2 * 16 + 3 * 3 + 6; // Every strobe issued below
localparam int N_FRAMES = 3;
localparam int LIMIT    = N_XFERS * 50 + N_FRAMES * 10 * CLKS + 1000; // In cycles
localparam logic [`DATA_W-1:0] UART_BASE = `SEL_UART << `SEL_LSB;

logic               clk_i;
logic               rst_i;
logic               hs_read_i;
logic               hs_write_i;
logic [`DATA_W-1:0] hs_addr_i;
logic [`DATA_W-1:0] hs_data_i;
logic [`STRB_W-1:0] hs_byte_sel_i;
logic               hs_ready_o;
logic [`DATA_W-1:0] hs_data_o;
logic [1:0]         hs_resp_o;
logic               tx_o;

logic [`DATA_W-1:0] model [`RAM_WORDS]; // Expected RAM contents
logic [`DATA_W-1:0] waddr [N_WORDS];
logic [`DATA_W-`SEL_LSB-1:0] bad_sel [3] = '{1, 3, '1}; // Unmapped slots
logic [`DATA_W-1:0] exp_addr_q [$];
logic [`DATA_W-1:0] exp_data_q [$];
logic [1:0]         exp_resp_q [$];
logic               exp_rd_q [$];   // Data compared for reads only
logic [7:0]         exp_bytes [$];  // Frames still due on tx_o
logic [`DATA_W-1:0] cmp_addr;
logic [`DATA_W-1:0] cmp_data;
logic [1:0]         cmp_resp;
logic               cmp_rd;
integer             seed = 45190;
int                 bus_errs = 0;
int                 serial_errs = 0;
int                 cycle_cnt = 0;
int                 ready_cycle = 0;

soc_top UUT (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.hs_read_i(hs_read_i),
	.hs_write_i(hs_write_i),
	.hs_addr_i(hs_addr_i),
	.hs_data_i(hs_data_i),
	.hs_byte_sel_i(hs_byte_sel_i),
	.hs_ready_o(hs_ready_o),
	.hs_data_o(hs_data_o),
	.hs_resp_o(hs_resp_o),
	.tx_o(tx_o)
);

initial begin
	clk_i = 1'b0;
	forever #4 clk_i = ~clk_i; // 8 ns period
end

always @(posedge clk_i)
	cycle_cnt <= cycle_cnt + 1;

// Reference merge where lanes with sel set take the new byte
function automatic logic [`DATA_W-1:0] merge_lanes(input logic [`DATA_W-1:0] old_w,
	input logic [`DATA_W-1:0] new_w, input logic [`STRB_W-1:0] sel);
	logic [`DATA_W-1:0] res;
	res = old_w;
	for (int b = 0; b < `STRB_W; b++) begin
		if (sel[b])
			res[8*b +: 8] = new_w[8*b +: 8];
	end
	return res;
endfunction

function automatic logic [`DATA_W-1:0] expected_word(input logic [`DATA_W-1:0] addr);
	return model[addr[`RAM_AW+1:2]]; // Select bits alias
endfunction

// One strobe then wait for the ready pulse
task automatic run_xfer(input logic wr, input logic [`DATA_W-1:0] addr,
	input logic [`DATA_W-1:0] data, input logic [`STRB_W-1:0] sel,
	input logic [1:0] resp, input logic [`DATA_W-1:0] rdata);
	exp_addr_q.push_back(addr);
	exp_data_q.push_back(rdata);
	exp_resp_q.push_back(resp);
	exp_rd_q.push_back(!wr);
	@(posedge clk_i);
	hs_read_i     <= !wr;
	hs_write_i    <= wr;
	hs_addr_i     <= addr;
	hs_data_i     <= data;
	hs_byte_sel_i <= sel;
	@(posedge clk_i);
	hs_read_i  <= 1'b0;
	hs_write_i <= 1'b0;
	@(negedge clk_i);
	while (!hs_ready_o)
		@(negedge clk_i);
	ready_cycle = cycle_cnt;
endtask

task automatic store_word(input logic [`DATA_W-1:0] addr, input logic [`DATA_W-1:0] data,
	input logic [`STRB_W-1:0] sel);
	model[addr[`RAM_AW+1:2]] = merge_lanes(model[addr[`RAM_AW+1:2]], data, sel);
	run_xfer(1'b1, addr, data, sel, soc_pkg::OKAY, '0);
endtask

task automatic load_check(input logic [`DATA_W-1:0] addr);
	run_xfer(1'b0, addr, '0, '0, soc_pkg::OKAY, expected_word(addr));
endtask

// Compare at each ready pulse
always @(negedge clk_i) begin
	if (!rst_i && hs_ready_o) begin
		if (exp_resp_q.size() == 0) begin
			$display("hs_ready_o pulsed at %0t with no transaction pending", $time);
			bus_errs++;
		end else begin
			cmp_addr = exp_addr_q.pop_front();
			cmp_data = exp_data_q.pop_front();
			cmp_resp = exp_resp_q.pop_front();
			cmp_rd   = exp_rd_q.pop_front();
			if (hs_resp_o !== cmp_resp) begin
				$display("ERROR %0t: addr 0x%08h resp %0d, expected %0d",
					$time, cmp_addr, hs_resp_o, cmp_resp);
				bus_errs++;
			end
			if (cmp_rd && hs_data_o !== cmp_data) begin
				$display("ERROR %0t: addr 0x%08h read 0x%08h, expected 0x%08h",
					$time, cmp_addr, hs_data_o, cmp_data);
				bus_errs++;
			end
		end
	end
end

// Serial monitor sampling mid-bit
initial begin
	logic [7:0] rx;
	logic [7:0] exp_b;
	@(negedge rst_i);
	forever begin
		@(negedge tx_o);
		repeat (CLKS / 2) @(negedge clk_i);
		if (tx_o !== 1'b0) begin
			$display("ERROR %0t: start bit not low at mid-bit", $time);
			serial_errs++;
		end
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS) @(negedge clk_i);
			rx[i] = tx_o; // LSB first
		end
		repeat (CLKS) @(negedge clk_i);
		if (tx_o !== 1'b1) begin
			$display("ERROR %0t: stop bit not high", $time);
			serial_errs++;
		end
		if (exp_bytes.size() == 0) begin
			$display("Unexpected frame on tx_o with byte 0x%02h", rx);
			serial_errs++;
		end else begin
			exp_b = exp_bytes.pop_front();
			if (rx !== exp_b) begin
				$display("ERROR %0t: tx byte 0x%02h, expected 0x%02h", $time, rx, exp_b);
				serial_errs++;
			end
		end
	end
end

initial begin
	repeat (LIMIT) @(posedge clk_i);
	$display("Watchdog expired, run did not finish within %0d cycles", LIMIT);
	$display("FAIL: see errors above");
	$finish;
end

initial begin
	logic [`DATA_W-1:0] a;
	logic [`DATA_W-1:0] d;
	logic               low_seen;
	int                 prev;
	rst_i         <= 1'b1;
	hs_read_i     <= 1'b0;
	hs_write_i    <= 1'b0;
	hs_addr_i     <= '0;
	hs_data_i     <= '0;
	hs_byte_sel_i <= '0;
	repeat (3) @(posedge clk_i);
	rst_i <= 1'b0;

	// Idle line and no ready before any strobe
	@(negedge clk_i);
	if (tx_o !== 1'b1 || hs_ready_o !== 1'b0) begin
		$display("ERROR %0t: after reset tx_o %b hs_ready_o %b", $time, tx_o, hs_ready_o);
		bus_errs++;
	end
	repeat (4) @(negedge clk_i); // Stray ready caught by the compare process

	// Full words with random alias bits in the RAM slot
	for (int k = 0; k < N_WORDS; k++) begin
		waddr[k] = $random(seed) & 32'h0001_FFFC;
		store_word(waddr[k], $random(seed), '1);
	end
	for (int k = 0; k < N_WORDS; k++)
		load_check(waddr[k]);

	// Partial writes
	for (int k = 0; k < 16; k++)
		store_word(waddr[k], $random(seed), $random(seed));
	for (int k = 0; k < 16; k++)
		load_check(waddr[k]);

	// Unmapped select values
	for (int k = 0; k < 3; k++) begin
		a = waddr[k];
		a[`DATA_W-1:`SEL_LSB] = bad_sel[k];
		run_xfer(1'b1, a, $random(seed), '1, soc_pkg::DECERR, '0);
		run_xfer(1'b0, a, '0, '0, soc_pkg::DECERR, '0);
		load_check(waddr[k]); // RAM word untouched
	end

	// UART writes each held off by the frame before
	for (int k = 0; k < 3; k++) begin
		d = $random(seed);
		exp_bytes.push_back(d[7:0]);
		prev = ready_cycle;
		run_xfer(1'b1, UART_BASE, d, 4'b0001, soc_pkg::OKAY, '0);
		if (k > 0 && ready_cycle - prev < 10 * CLKS) begin
			$display("ERROR %0t: UART write %0d done %0d cycles after previous",
				$time, k, ready_cycle - prev);
			bus_errs++;
		end
	end
	run_xfer(1'b0, UART_BASE + 4, '0, '0, soc_pkg::OKAY, 1); // Busy
	while (exp_bytes.size() != 0)
		@(negedge clk_i);
	repeat (CLKS) @(negedge clk_i); // Rest of stop bit
	run_xfer(1'b0, UART_BASE + 4, '0, '0, soc_pkg::OKAY, 0);

	// Status register is read-only
	run_xfer(1'b1, UART_BASE + 4, $random(seed), '1, soc_pkg::SLVERR, '0);
	low_seen = 1'b0;
	repeat (10 * CLKS) begin
		@(negedge clk_i);
		if (tx_o !== 1'b1)
			low_seen = 1'b1;
	end
	if (low_seen) begin
		$display("ERROR %0t: tx_o left idle after status write", $time);
		serial_errs++;
	end

	if (exp_bytes.size() != 0) begin
		$display("Serial monitor missed %0d frame(s)", exp_bytes.size());
		serial_errs++;
	end
	$display("Errors: bus %0d, serial %0d", bus_errs, serial_errs);
	if (bus_errs + serial_errs == 0)
		$display("PASS: all tests");
	else
		$display("FAIL: see errors above");
	$finish;
end

endmodule

// File: vlog.f
+incdir+.
soc_pkg.sv
axi_lite_if.sv
axi_master.sv
axi_addr_decoder.sv
axi_ram.sv
axi_uart_tx.sv
soc_top.sv
tb_soc_top.sv
